// File: rtl/kbd_pkg.sv
package kbd_pkg;

    typedef logic [7:0] byte_t;

    // Decoded scan code; low 9 bits form the translation ROM address
    typedef struct packed {
        logic  is_break;
        logic  extended;
        byte_t code;
    } ps2_kbd_event_t;

    // Translated event as stored in the FIFO
    typedef struct packed {
        logic  is_break;
        byte_t vk;
    } kbd_event_t;

    localparam byte_t PS2_PREFIX_EXT   = 8'hE0;
    localparam byte_t PS2_PREFIX_BREAK = 8'hF0;

    localparam int FIFO_ADDR_WIDTH = 5;

    localparam string KROM_FILE = "krom.mem";

    localparam int AXI_ADDR_WIDTH = 4;
    localparam int AXI_DATA_WIDTH = 32;

    // Register byte offsets
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_DATA   = 4'h0;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS = 4'h4;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL   = 4'h8;

    // STATUS bit positions
    localparam int STATUS_NOT_EMPTY = 0;
    localparam int STATUS_OVERFLOW  = 1;
    localparam int STATUS_FRAME_ERR = 2;

endpackage

// File: rtl/ps2_rx.sv
module ps2_rx
    import kbd_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  ps2_clk_i,
    input  logic  ps2_data_i,
    output byte_t data_o,
    output logic  valid_o,
    output logic  frame_err_o
);

    logic [1:0] clk_sync_r;
    logic [1:0] data_sync_r;
    logic       clk_prev_r;
    logic       clk_fall;
    logic [3:0] bit_cnt_r;
    logic [9:0] shift_r;
    logic       frame_done_r;
    logic       check_r;
    logic       parity_ok_r;
    logic       stop_ok_r;

    // Both lines idle high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync_r  <= 2'b11;
            data_sync_r <= 2'b11;
            clk_prev_r  <= 1'b1;
        end else begin
            clk_sync_r  <= {clk_sync_r[0], ps2_clk_i};
            data_sync_r <= {data_sync_r[0], ps2_data_i};
            clk_prev_r  <= clk_sync_r[1];
        end
    end

    assign clk_fall = clk_prev_r & ~clk_sync_r[1];

    // Count start, 8 data, parity and stop bits
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bit_cnt_r    <= '0;
            frame_done_r <= 1'b0;
        end else begin
            frame_done_r <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt_r == 4'd10) begin
                    bit_cnt_r    <= '0;
                    frame_done_r <= 1'b1;
                end else begin
                    bit_cnt_r <= bit_cnt_r + 4'd1;
                end
            end
        end
    end

    // Start bit drops out the bottom after the stop bit arrives
    always_ff @(posedge clk_i) begin
        if (clk_fall) begin
            shift_r <= {data_sync_r[1], shift_r[9:1]};
        end
    end

    // Check stage
    always_ff @(posedge clk_i) begin
        if (frame_done_r) begin
            data_o      <= shift_r[7:0];
            parity_ok_r <= ^shift_r[8:0];
            stop_ok_r   <= shift_r[9];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            check_r     <= 1'b0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            check_r     <= frame_done_r;
            valid_o     <= check_r & parity_ok_r & stop_ok_r;
            frame_err_o <= check_r & ~(parity_ok_r & stop_ok_r);
        end
    end

endmodule

// File: rtl/ps2_kbd.sv
module ps2_kbd
    import kbd_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  byte_t          data_i,
    input  logic           valid_i,
    output ps2_kbd_event_t event_o,
    output logic           valid_o
);

    logic extended_r;
    logic break_r;
    logic is_prefix;
    logic code_byte;

    assign is_prefix = (data_i == PS2_PREFIX_EXT) || (data_i == PS2_PREFIX_BREAK);
    assign code_byte = valid_i & ~is_prefix;

    // Prefix flags live until the next code byte
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            extended_r <= 1'b0;
            break_r    <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            valid_o <= code_byte;
            if (valid_i) begin
                if (data_i == PS2_PREFIX_EXT) begin
                    extended_r <= 1'b1;
                end else if (data_i == PS2_PREFIX_BREAK) begin
                    break_r <= 1'b1;
                end else begin
                    extended_r <= 1'b0;
                    break_r    <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (code_byte) begin
            event_o <= '{is_break: break_r, extended: extended_r, code: data_i};
        end
    end

endmodule

// File: rtl/keycode_rom.sv
module keycode_rom
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       read_enable_i,
    input  logic [8:0] read_addr_i,
    output byte_t      read_data_o
);

    byte_t rom [0:511];

    // Codes missing from the table translate to 0
    initial begin
        for (int i = 0; i < 512; i++) begin
            rom[i] = '0;
        end
        $readmemh(KROM_FILE, rom);
    end

    always_ff @(posedge clk_i) begin
        if (read_enable_i) begin
            read_data_o <= rom[read_addr_i];
        end
    end

endmodule

// File: rtl/kbd_fifo.sv
module kbd_fifo
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  kbd_event_t write_data_i,
    input  logic       write_enable_i,
    input  logic       pop_i,
    output kbd_event_t head_o,
    output logic       empty_o,
    output logic       overflow_o
);

    kbd_event_t mem [2**FIFO_ADDR_WIDTH];

    // Extra MSB tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr_r;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr_r;
    logic                     full;
    logic                     do_write;

    assign empty_o  = (wr_ptr_r == rd_ptr_r);
    assign full     = (wr_ptr_r[FIFO_ADDR_WIDTH] != rd_ptr_r[FIFO_ADDR_WIDTH]) &&
                      (wr_ptr_r[FIFO_ADDR_WIDTH-1:0] == rd_ptr_r[FIFO_ADDR_WIDTH-1:0]);
    assign do_write = write_enable_i & ~full;

    // Head shows straight from the array
    assign head_o = mem[rd_ptr_r[FIFO_ADDR_WIDTH-1:0]];

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr_r[FIFO_ADDR_WIDTH-1:0]] <= write_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // Write into a full buffer is lost
            overflow_o <= write_enable_i & full;
        end
    end

endmodule

// File: rtl/kbd_controller.sv
module kbd_controller
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    input  logic       pop_i,
    output kbd_event_t head_o,
    output logic       empty_o,
    output logic       overflow_o,
    output logic       frame_err_o
);

    byte_t          rx_data;
    logic           rx_valid;
    ps2_kbd_event_t scan_event;
    logic           scan_valid;
    byte_t          vk;
    logic           is_break_r;
    logic           vk_valid_r;
    kbd_event_t     fifo_wdata;

    ps2_rx u_ps2_rx (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ps2_clk_i   (ps2_clk_i),
        .ps2_data_i  (ps2_data_i),
        .data_o      (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err_o)
    );

    ps2_kbd u_ps2_kbd (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (rx_data),
        .valid_i (rx_valid),
        .event_o (scan_event),
        .valid_o (scan_valid)
    );

    keycode_rom u_krom (
        .clk_i         (clk_i),
        .read_enable_i (scan_valid),
        .read_addr_i   ({scan_event.extended, scan_event.code}),
        .read_data_o   (vk)
    );

    // Delay break flag and valid to meet the ROM output
    always_ff @(posedge clk_i) begin
        is_break_r <= scan_event.is_break;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vk_valid_r <= 1'b0;
        end else begin
            vk_valid_r <= scan_valid;
        end
    end

    assign fifo_wdata = '{is_break: is_break_r, vk: vk};

    kbd_fifo u_fifo (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .write_data_i   (fifo_wdata),
        .write_enable_i (vk_valid_r),
        .pop_i          (pop_i),
        .head_o         (head_o),
        .empty_o        (empty_o),
        .overflow_o     (overflow_o)
    );

endmodule

// File: rtl/kbd_regs.sv
module kbd_regs
    import kbd_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata_i,
    input  logic [3:0]                s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i,

    input  kbd_event_t                head_i,
    input  logic                      empty_i,
    input  logic                      overflow_i,
    input  logic                      frame_err_i,
    output logic                      pop_o,
    output logic                      interrupt_o
);

    logic                      wr_accept;
    logic                      rd_accept;
    logic                      clr_overflow;
    logic                      clr_frame_err;
    logic                      overflow_r;
    logic                      frame_err_r;
    logic                      irq_en_r;
    logic [AXI_DATA_WIDTH-1:0] rdata_next;

    // One outstanding response per channel
    assign wr_accept = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_bvalid_o;
    assign rd_accept = s_axi_arvalid_i & ~s_axi_rvalid_o;

    assign s_axi_awready_o = wr_accept;
    assign s_axi_wready_o  = wr_accept;
    assign s_axi_arready_o = rd_accept;
    assign s_axi_bresp_o   = 2'b00;
    assign s_axi_rresp_o   = 2'b00;

    // All fields sit in byte 0, so s_axi_wstrb_i has no effect
    assign clr_overflow  = wr_accept && (s_axi_awaddr_i == REG_STATUS) &&
                           s_axi_wdata_i[STATUS_OVERFLOW];
    assign clr_frame_err = wr_accept && (s_axi_awaddr_i == REG_STATUS) &&
                           s_axi_wdata_i[STATUS_FRAME_ERR];

    // Pop the head as DATA is captured
    assign pop_o = rd_accept && (s_axi_araddr_i == REG_DATA) && !empty_i;

    always_comb begin
        rdata_next = '0;
        case (s_axi_araddr_i)
            REG_DATA: begin
                if (!empty_i) begin
                    rdata_next[31]  = 1'b1;
                    rdata_next[8:0] = head_i;
                end
            end
            REG_STATUS: begin
                rdata_next[STATUS_NOT_EMPTY] = ~empty_i;
                rdata_next[STATUS_OVERFLOW]  = overflow_r;
                rdata_next[STATUS_FRAME_ERR] = frame_err_r;
            end
            REG_CTRL: begin
                rdata_next[0] = irq_en_r;
            end
            default: begin
                rdata_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s_axi_bvalid_o <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
        end else begin
            if (wr_accept) begin
                s_axi_bvalid_o <= 1'b1;
            end else if (s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end
            if (rd_accept) begin
                s_axi_rvalid_o <= 1'b1;
            end else if (s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end
        end
    end

    // Held until the next accepted read
    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            s_axi_rdata_o <= rdata_next;
        end
    end

    // Sticky flags; a new event wins over a clear
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            overflow_r  <= 1'b0;
            frame_err_r <= 1'b0;
            irq_en_r    <= 1'b0;
            interrupt_o <= 1'b0;
        end else begin
            overflow_r  <= overflow_i | (overflow_r & ~clr_overflow);
            frame_err_r <= frame_err_i | (frame_err_r & ~clr_frame_err);
            if (wr_accept && (s_axi_awaddr_i == REG_CTRL)) begin
                irq_en_r <= s_axi_wdata_i[0];
            end
            interrupt_o <= irq_en_r & ~empty_i;
        end
    end

endmodule

// File: rtl/kbd_top.sv
module kbd_top
    import kbd_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      ps2_clk_i,
    input  logic                      ps2_data_i,

    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata_i,
    input  logic [3:0]                s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i,

    output logic                      interrupt_o
);

    kbd_event_t head;
    logic       empty;
    logic       pop;
    logic       overflow;
    logic       frame_err;

    kbd_controller u_ctrl (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ps2_clk_i   (ps2_clk_i),
        .ps2_data_i  (ps2_data_i),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .overflow_o  (overflow),
        .frame_err_o (frame_err)
    );

    kbd_regs u_regs (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .head_i          (head),
        .empty_i         (empty),
        .overflow_i      (overflow),
        .frame_err_i     (frame_err),
        .pop_o           (pop),
        .interrupt_o     (interrupt_o)
    );

endmodule

// File: sim/tb_clock.sv
module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

endmodule

// File: sim/kbd_tb.sv
module kbd_tb
    import kbd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PS2_HALF     = 20;
    localparam int          FRAME_GAP    = 40;
    localparam int          FRAME_CYCLES = 22 * PS2_HALF + FRAME_GAP;
    localparam int          NUM_KEYS     = 60;
    localparam int          FIFO_DEPTH   = 2**FIFO_ADDR_WIDTH;
    // Up to three frames per key, then error, overflow and interrupt tests
    localparam int          MAX_FRAMES   = 3 * NUM_KEYS + 2 + (FIFO_DEPTH + 1) + 3;
    localparam int          WATCHDOG_NS  = MAX_FRAMES * FRAME_CYCLES * 10 * 4;
    localparam int          POLL_LIMIT   = 50;
    localparam logic [31:0] SEED         = 32'hdbb5_9b15;

    logic        clk;
    logic        reset;
    logic        ps2_clk;
    logic        ps2_data;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        interrupt;

    // Reference translation table and expected FIFO contents
    byte_t       krom_model [0:511];
    kbd_event_t  expected_q [$];

    tb_clock u_clock (
        .clk_o (clk)
    );

    kbd_top UUT (
        .clk_i           (clk),
        .reset_i         (reset),
        .ps2_clk_i       (ps2_clk),
        .ps2_data_i      (ps2_data),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready),
        .interrupt_o     (interrupt)
    );

    // Ends 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic transmit_frame(input byte_t value, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = ~^value;
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, value, 1'b0};
        repeat (11) begin
            ps2_data = bits[0];
            bits     = bits >> 1;
            step(PS2_HALF);
            ps2_clk = 1'b0;
            step(PS2_HALF);
            ps2_clk = 1'b1;
        end
        step(FRAME_GAP);
    endtask

    task automatic send_key(input logic ext, input logic brk, input byte_t code);
        kbd_event_t ev;
        if (ext) begin
            transmit_frame(PS2_PREFIX_EXT, 1'b0);
        end
        if (brk) begin
            transmit_frame(PS2_PREFIX_BREAK, 1'b0);
        end
        transmit_frame(code, 1'b0);
        ev.is_break = brk;
        ev.vk       = krom_model[{ext, code}];
        // A full FIFO drops the event
        if (expected_q.size() < FIFO_DEPTH) begin
            expected_q.push_back(ev);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        int unsigned delay;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        // Address and data are taken in the same cycle
        check_value("wready", 32'h1, 32'(wready));
        step(1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        delay   = $urandom_range(3, 0);
        step(int'(delay));
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        check_value("bresp", 32'h0, 32'(bresp));
        step(1);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        int unsigned delay;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        step(1);
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        check_value("rresp", 32'h0, 32'(rresp));
        // rdata must not move while rready is low
        delay = $urandom_range(3, 0);
        repeat (delay) begin
            @(negedge clk);
            check_value("rdata hold", data, rdata);
        end
        step(1);
        rready = 1'b1;
        step(1);
        rready = 1'b0;
    endtask

    task automatic poll_not_empty();
        logic [31:0] status;
        int          tries;
        tries = 0;
        read_reg(REG_STATUS, status);
        while (!status[STATUS_NOT_EMPTY] && tries < POLL_LIMIT) begin
            tries++;
            read_reg(REG_STATUS, status);
        end
        if (!status[STATUS_NOT_EMPTY]) begin
            $display("FIFO stayed empty, an expected key event never arrived");
            $display("Simulation FAILED");
            $fatal(1, "missing key event");
        end
    endtask

    // Pop every expected event through DATA
    task automatic drain_events(input string name);
        kbd_event_t  ev;
        logic [31:0] value;
        while (expected_q.size() > 0) begin
            poll_not_empty();
            ev = expected_q.pop_front();
            read_reg(REG_DATA, value);
            check_value(name, {1'b1, 22'b0, ev}, value);
        end
    endtask

    task automatic sample_irq(input string name, input logic expected);
        @(negedge clk);
        check_value(name, 32'(expected), 32'(interrupt));
        step(1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] value;
        logic        ext;
        logic        brk;
        byte_t       code;
        int          batch;

        value      = $urandom(SEED);
        krom_model = '{default: 8'h00};
        $readmemh(KROM_FILE, krom_model);

        reset    = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        awaddr   = 4'h0;
        awvalid  = 1'b0;
        wdata    = 32'h0;
        wstrb    = 4'hf;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 4'h0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        step(16);
        reset = 1'b0;

        @(negedge clk);
        check_value("reset awready", 32'h0, 32'(awready));
        check_value("reset wready", 32'h0, 32'(wready));
        check_value("reset arready", 32'h0, 32'(arready));
        check_value("reset bvalid", 32'h0, 32'(bvalid));
        check_value("reset rvalid", 32'h0, 32'(rvalid));
        check_value("reset interrupt", 32'h0, 32'(interrupt));
        step(1);
        read_reg(REG_STATUS, value);
        check_value("reset STATUS", 32'h0, value);
        read_reg(REG_CTRL, value);
        check_value("reset CTRL", 32'h0, value);

        // Random make, break and extended keys, drained in small batches
        batch = int'($urandom_range(8, 1));
        for (int i = 0; i < NUM_KEYS; i++) begin
            ext  = 1'($urandom_range(1, 0));
            brk  = 1'($urandom_range(1, 0));
            code = 8'($urandom_range(8'h7f, 8'h01));
            send_key(ext, brk, code);
            if (expected_q.size() >= batch || i == NUM_KEYS - 1) begin
                drain_events("key event");
                batch = int'($urandom_range(8, 1));
            end
        end

        read_reg(REG_DATA, value);
        check_value("empty DATA", 32'h0, value);

        // Bad parity frame
        code = 8'($urandom_range(8'h7f, 8'h01));
        transmit_frame(code, 1'b1);
        read_reg(REG_STATUS, value);
        check_value("frame error status", 32'h4, value);
        write_reg(REG_STATUS, 32'h4);
        read_reg(REG_STATUS, value);
        check_value("frame error clear", 32'h0, value);
        send_key(1'b0, 1'b0, code);
        drain_events("after frame error");

        // One event more than the FIFO holds
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            send_key(1'b0, 1'b0, 8'($urandom_range(8'h7f, 8'h01)));
        end
        read_reg(REG_STATUS, value);
        check_value("overflow status", 32'h3, value);
        drain_events("overflow order");
        read_reg(REG_DATA, value);
        check_value("drained DATA", 32'h0, value);
        write_reg(REG_STATUS, 32'h2);
        read_reg(REG_STATUS, value);
        check_value("overflow clear", 32'h0, value);

        // Interrupt enable and level
        write_reg(REG_CTRL, 32'h0);
        read_reg(REG_CTRL, value);
        check_value("CTRL readback 0", 32'h0, value);
        send_key(1'b0, 1'b0, code);
        poll_not_empty();
        sample_irq("irq disabled", 1'b0);
        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_CTRL, value);
        check_value("CTRL readback 1", 32'h1, value);
        sample_irq("irq enabled", 1'b1);
        drain_events("irq pop");
        sample_irq("irq after last pop", 1'b0);
        send_key(1'b1, 1'b0, code);
        poll_not_empty();
        sample_irq("irq new event", 1'b1);

        // Unmapped offset while DATA, STATUS and CTRL all read nonzero
        read_reg(4'hC, value);
        check_value("unmapped read", 32'h0, value);

        drain_events("irq extended pop");
        sample_irq("irq empty again", 1'b0);
        write_reg(REG_CTRL, 32'h0);
        read_reg(REG_CTRL, value);
        check_value("CTRL cleared", 32'h0, value);

        // Unmapped write
        write_reg(4'hC, 32'hffff_ffff);
        read_reg(REG_CTRL, value);
        check_value("unmapped write", 32'h0, value);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: rtl/krom.mem
// Scan-code to virtual-key table, zero where no entry is given
// Columns: @address value, address = {extended, code}, value = virtual-key code
@00D 09  @012 A0
@014 A2  @015 51
@016 31  @01A 5A
@01B 53  @01C 41
@01D 57  @01E 32
@021 43  @022 58
@023 44  @024 45
@025 34  @026 33
@029 20  @02A 56
@02B 46  @02C 54
@02D 52  @02E 35
@031 4E  @032 42
@033 48  @034 47
@035 59  @036 36
@03A 4D  @03B 4A
@03C 55  @03D 37
@03E 38  @042 4B
@043 49  @044 4F
@045 30  @046 39
@04B 4C  @04D 50
@05A 0D  @066 08
@076 1B
// Extended keys, E0 prefix
@114 A3  @169 23
@16B 25  @16C 24
@171 2E  @172 28
@174 27  @175 26

// File: files.f
rtl/kbd_pkg.sv
rtl/ps2_rx.sv
rtl/ps2_kbd.sv
rtl/keycode_rom.sv
rtl/kbd_fifo.sv
rtl/kbd_controller.sv
rtl/kbd_regs.sv
rtl/kbd_top.sv
sim/tb_clock.sv
sim/kbd_tb.sv

// File: run_sim.sh
#!/bin/sh
# krom.mem is opened by name, so the binary runs inside rtl/
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module kbd_tb -f files.f \
    && cd rtl && ../obj_dir/Vkbd_tb \
    || { echo "kbd_tb build or run did not succeed" >&2; exit 1; }
